/* include/sircHandler_consts.svh */
/*
 * Shared constants for the host-session controller
 *  - host bus address widths
 *  - session lengths and calibration wait
 *  - operating mode codes
 */
`ifndef SIRC_HANDLER_CONSTS_SVH
`define SIRC_HANDLER_CONSTS_SVH

////////////////////////////////////////
// Host bus widths
`define SIRC_REG_ADDR_W 8      // Parameter register file
`define SIRC_IN_ADDR_W 17      // Input memory, byte addressed
`define SIRC_OUT_ADDR_W 13     // Output memory, byte addressed

////////////////////////////////////////
// Session lengths
`define SIRC_PDL_BYTES 16      // Delay-line configuration bytes
`define SIRC_RESULT_LEN 16     // Result buffer bytes
`define SIRC_CALIB_WAIT 10     // Trigger to writeback in calibration

// Mode word codes, anything else is normal test
`define SIRC_MODE_CALIB 0
`define SIRC_MODE_TEMP 1

`endif

/* design/sircBusPkg.sv */
/*
 * Host bus port types
 *  - parameter register request and response
 *  - input memory read request and response
 *  - output memory write request
 */
`include "sircHandler_consts.svh"

package sircBusPkg;

	////////////////////////////////////////
	// Parameter register file, read only

	typedef struct packed {
		logic cmdReq;                             // Held until cmdAck
		logic [`SIRC_REG_ADDR_W-1:0] address;
	} regReq_t;

	typedef struct packed {
		logic cmdAck;
		logic readDataValid;                      // Read returns some cycles later
		logic [31:0] readData;
	} regResp_t;

	////////////////////////////////////////
	// Input and output memories, one byte per access

	typedef struct packed {
		logic readReq;
		logic [`SIRC_IN_ADDR_W-1:0] address;
	} inMemReq_t;

	typedef struct packed {
		logic readAck;
		logic readDataValid;
		logic [7:0] data;
	} inMemResp_t;

	typedef struct packed {
		logic writeReq;                           // Accepted together with outMemWriteAck
		logic [`SIRC_OUT_ADDR_W-1:0] address;
		logic [7:0] data;
	} outMemReq_t;

endpackage

/* design/pufPkg.sv */
/*
 * PUF side types
 *  - operating mode and session state enums
 *  - evaluation request and response structs
 */
`include "sircHandler_consts.svh"

package pufPkg;

	typedef enum logic [1:0] {
		ModeCalib = 2'(`SIRC_MODE_CALIB),   // Raw response after fixed wait
		ModeTemp  = 2'(`SIRC_MODE_TEMP),    // Temperature read through the buffer
		ModeTest  = 2'd2                    // Normal test
	} pufMode_t;

	// Session sequence, one pass per run flag
	typedef enum logic [2:0] {
		StIdle,
		StFetch,      // Parameter words
		StLoad,       // Delay-line configuration
		StCompute,    // PUF evaluation
		StWrite,      // Output memory writeback
		StClear       // Run flag clear
	} sessionState_t;

	typedef struct packed {
		logic trigger;                             // One cycle, calibration only
		logic testStart;                           // Level, held until testDone
		pufMode_t mode;
		logic [31:0] challenge;
		logic [8*`SIRC_PDL_BYTES-1:0] pdlConfig;
	} pufReq_t;

	typedef struct packed {
		logic testDone;
		logic [15:0] rawResponse;
		logic bufWe;                               // Result buffer write port
		logic [$clog2(`SIRC_RESULT_LEN)-1:0] bufAddr;
		logic [7:0] bufData;
	} pufResp_t;

endpackage

/* design/paramFetch.sv */
/*
 * paramFetch
 *  Reads mode word and challenge from register addresses 0 and 1,
 *  decodes the mode word
 */
`timescale 1ns/1ps
`include "sircHandler_consts.svh"

module paramFetch (
	input  logic clk,
	input  logic reset,
	input  logic start,
	output sircBusPkg::regReq_t regReq,
	input  sircBusPkg::regResp_t regResp,
	output pufPkg::pufMode_t mode,
	output logic [31:0] challenge,
	output logic done
);

	logic busy;               // Waiting for read data
	logic gotFirst;           // First word already shifted in
	logic [31:0] modeWord;

	// Request side and completion
	always_ff @(posedge clk) begin
		if (reset) begin
			regReq <= '0;
			busy <= 1'b0;
			gotFirst <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				regReq.cmdReq <= 1'b1;
				regReq.address <= '0;
				busy <= 1'b1;
				gotFirst <= 1'b0;
			end else if (regReq.cmdReq && regResp.cmdAck) begin
				if (regReq.address == `SIRC_REG_ADDR_W'(1))
					regReq.cmdReq <= 1'b0;                      // Both reads issued
				else
					regReq.address <= regReq.address + 1'b1;
			end
			if (busy && regResp.readDataValid) begin
				gotFirst <= 1'b1;
				if (gotFirst) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// Two-word shift, first word ends up as mode word
	always_ff @(posedge clk) begin
		if (busy && regResp.readDataValid) begin
			modeWord <= challenge;
			challenge <= regResp.readData;
		end
	end

	always_comb begin
		if (modeWord == 32'(`SIRC_MODE_CALIB))
			mode = pufPkg::ModeCalib;
		else if (modeWord == 32'(`SIRC_MODE_TEMP))
			mode = pufPkg::ModeTemp;
		else
			mode = pufPkg::ModeTest;                          // Any other word
	end

	// Only two parameters exist on the register file
	assert property (@(posedge clk) disable iff (reset)
		regReq.cmdReq |-> regReq.address <= `SIRC_REG_ADDR_W'(1));

endmodule

/* design/challengeLoader.sv */
/*
 * challengeLoader
 *  Reads the delay-line configuration bytes from input memory,
 *  one read outstanding at a time, into the 128-bit pdlConfig
 */
`timescale 1ns/1ps
`include "sircHandler_consts.svh"

module challengeLoader (
	input  logic clk,
	input  logic reset,
	input  logic start,
	output sircBusPkg::inMemReq_t inReq,
	input  sircBusPkg::inMemResp_t inResp,
	output logic [8*`SIRC_PDL_BYTES-1:0] pdlConfig,
	output logic done
);

	localparam int laneW = $clog2(`SIRC_PDL_BYTES);
	localparam int lastAddr = `SIRC_PDL_BYTES - 1;

	logic busy;
	logic [laneW-1:0] lane;

	// Address of the read in flight selects the byte lane
	assign lane = inReq.address[laneW-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			inReq <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				inReq.readReq <= 1'b1;
				inReq.address <= '0;
				busy <= 1'b1;
			end else if (inReq.readReq && inResp.readAck) begin
				inReq.readReq <= 1'b0;                      // Accepted, wait for data
			end

			if (busy && inResp.readDataValid) begin
				if (inReq.address == `SIRC_IN_ADDR_W'(lastAddr)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					// Next byte
					inReq.readReq <= 1'b1;
					inReq.address <= inReq.address + 1'b1;
				end
			end
		end
	end

	// Byte i lands at bits 8*i+7 .. 8*i
	always_ff @(posedge clk) begin
		if (busy && inResp.readDataValid)
			pdlConfig[8*lane +: 8] <= inResp.data;
	end

endmodule

/* design/resultBuffer.sv */
/*
 * resultBuffer
 *  Result byte RAM, written by the PUF,
 *  registered read for writeback
 */
`timescale 1ns/1ps
`include "sircHandler_consts.svh"

module resultBuffer (
	input  logic clk,
	input  pufPkg::pufResp_t pufResp,
	input  logic [$clog2(`SIRC_RESULT_LEN)-1:0] readAddr,
	output logic [7:0] readData
);

	logic [7:0] mem [`SIRC_RESULT_LEN];

	always_ff @(posedge clk) begin
		if (pufResp.bufWe)
			mem[pufResp.bufAddr] <= pufResp.bufData;     // PUF write port
		readData <= mem[readAddr];                      // One cycle read latency
	end

endmodule

/* design/outputWriter.sv */
/*
 * outputWriter
 *  Streams result bytes to output memory from address 0
 *  - calibration: raw response, upper byte first
 *  - temperature and test: result buffer, prefetched one cycle ahead
 */
`timescale 1ns/1ps
`include "sircHandler_consts.svh"

module outputWriter (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  pufPkg::pufMode_t mode,
	input  logic [15:0] rawResponse,
	output logic [$clog2(`SIRC_RESULT_LEN)-1:0] bufAddr,
	input  logic [7:0] bufData,
	output sircBusPkg::outMemReq_t outReq,
	input  logic writeAck,
	output logic done
);

	typedef enum logic [1:0] {
		WrIdle,
		WrPrefetch,   // RAM registers byte 0
		WrLoad,       // Byte ready, raise request
		WrWait        // Request held until writeAck
	} wrState_t;

	wrState_t state;
	logic [`SIRC_OUT_ADDR_W-1:0] lastAddr;
	logic [7:0] nextByte;

	always_comb begin
		if (mode == pufPkg::ModeCalib) begin
			lastAddr = `SIRC_OUT_ADDR_W'(1);                          // Two raw bytes
			nextByte = outReq.address[0] ? rawResponse[7:0] : rawResponse[15:8];
		end else begin
			lastAddr = `SIRC_OUT_ADDR_W'(`SIRC_RESULT_LEN - 1);
			nextByte = bufData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= WrIdle;
			outReq <= '0;
			bufAddr <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				WrIdle: if (start) begin
					bufAddr <= '0;
					outReq.address <= '0;
					state <= WrPrefetch;
				end
				WrPrefetch: state <= WrLoad;
				WrLoad: begin
					outReq.writeReq <= 1'b1;
					outReq.data <= nextByte;
					bufAddr <= bufAddr + 1'b1;       // Prefetch following byte
					state <= WrWait;
				end
				WrWait: if (writeAck) begin
					outReq.writeReq <= 1'b0;
					if (outReq.address == lastAddr) begin
						done <= 1'b1;
						state <= WrIdle;
					end else begin
						outReq.address <= outReq.address + 1'b1;
						state <= WrLoad;
					end
				end
				default: state <= WrIdle;
			endcase
		end
	end

	// Request holds address and data until accepted
	assert property (@(posedge clk) disable iff (reset)
		outReq.writeReq && !writeAck |=>
			outReq.writeReq && $stable(outReq.address) && $stable(outReq.data));

endmodule

/* design/sessionControl.sv */
/*
 * sessionControl
 *  Session FSM: fetch, load, compute, write, clear
 *  Calibration wait counter and PUF start/done sequencing
 */
`timescale 1ns/1ps
`include "sircHandler_consts.svh"

module sessionControl (
	input  logic clk,
	input  logic reset,
	input  logic runValue,
	output logic runClear,
	output logic fetchStart,
	input  logic fetchDone,
	output logic loadStart,
	input  logic loadDone,
	output logic writeStart,
	input  logic writeDone,
	input  pufPkg::pufMode_t mode,
	input  logic [31:0] challenge,
	input  logic [8*`SIRC_PDL_BYTES-1:0] pdlConfig,
	output pufPkg::pufReq_t pufReq,
	input  logic testDone
);

	localparam int waitW = $clog2(`SIRC_CALIB_WAIT + 1);

	pufPkg::sessionState_t state;
	logic trigger;
	logic testStart;
	logic [waitW-1:0] waitCnt;   // Cycles since trigger

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= pufPkg::StIdle;
			fetchStart <= 1'b0;
			loadStart <= 1'b0;
			writeStart <= 1'b0;
			runClear <= 1'b0;
			trigger <= 1'b0;
			testStart <= 1'b0;
			waitCnt <= '0;
		end else begin
			// Pulses by default
			fetchStart <= 1'b0;
			loadStart <= 1'b0;
			writeStart <= 1'b0;
			trigger <= 1'b0;
			case (state)
				pufPkg::StIdle: if (runValue && !runClear) begin
					fetchStart <= 1'b1;
					state <= pufPkg::StFetch;
				end
				pufPkg::StFetch: if (fetchDone) begin
					loadStart <= 1'b1;
					state <= pufPkg::StLoad;
				end
				pufPkg::StLoad: if (loadDone) begin
					waitCnt <= '0;
					state <= pufPkg::StCompute;
					if (mode == pufPkg::ModeCalib)
						trigger <= 1'b1;
					else
						testStart <= 1'b1;
				end
				pufPkg::StCompute: begin
					if (mode == pufPkg::ModeCalib) begin
						// Trigger was high when waitCnt was 0
						waitCnt <= waitCnt + 1'b1;
						if (waitCnt == waitW'(`SIRC_CALIB_WAIT - 1)) begin
							writeStart <= 1'b1;
							state <= pufPkg::StWrite;
						end
					end else if (testDone) begin
						testStart <= 1'b0;
						writeStart <= 1'b1;
						state <= pufPkg::StWrite;
					end
				end
				pufPkg::StWrite: if (writeDone) begin
					runClear <= 1'b1;            // One cycle clear of run flag
					state <= pufPkg::StClear;
				end
				pufPkg::StClear: begin
					runClear <= 1'b0;
					state <= pufPkg::StIdle;
				end
				default: state <= pufPkg::StIdle;
			endcase
		end
	end

	always_comb begin
		pufReq.trigger = trigger;
		pufReq.testStart = testStart;
		pufReq.mode = mode;
		pufReq.challenge = challenge;
		pufReq.pdlConfig = pdlConfig;
	end

	// Decoded mode from paramFetch never starts a test in calibration
	assert property (@(posedge clk) disable iff (reset)
		pufReq.testStart |-> pufReq.mode != pufPkg::ModeCalib);

endmodule

/* design/sircHandler.sv */
/*
 * sircHandler
 *  Top level of the host-session controller,
 *  parameter fetch, configuration load, session FSM,
 *  result buffer and output writer
 */
`timescale 1ns/1ps
`include "sircHandler_consts.svh"

module sircHandler (
	input  logic clk,
	input  logic reset,
	input  logic runValue,
	output logic runClear,
	output sircBusPkg::regReq_t regReq,
	input  sircBusPkg::regResp_t regResp,
	output sircBusPkg::inMemReq_t inMemReq,
	input  sircBusPkg::inMemResp_t inMemResp,
	output sircBusPkg::outMemReq_t outMemReq,
	input  logic outMemWriteAck,
	output pufPkg::pufReq_t pufReq,
	input  pufPkg::pufResp_t pufResp
);

	logic fetchStart, fetchDone;
	logic loadStart, loadDone;
	logic writeStart, writeDone;
	pufPkg::pufMode_t mode;
	logic [31:0] challenge;
	logic [8*`SIRC_PDL_BYTES-1:0] pdlConfig;
	logic [$clog2(`SIRC_RESULT_LEN)-1:0] bufAddr;
	logic [7:0] bufData;

	////////////////////////////////////////
	// Session sequencing

	sessionControl u_ctrl (.clk, .reset, .runValue, .runClear,
		.fetchStart, .fetchDone, .loadStart, .loadDone, .writeStart, .writeDone,
		.mode, .challenge, .pdlConfig, .pufReq, .testDone(pufResp.testDone));

	////////////////////////////////////////
	// Host bus sides

	paramFetch u_fetch (.clk, .reset, .start(fetchStart), .regReq, .regResp,
		.mode, .challenge, .done(fetchDone));

	challengeLoader u_load (.clk, .reset, .start(loadStart), .inReq(inMemReq),
		.inResp(inMemResp), .pdlConfig, .done(loadDone));

	resultBuffer u_buf (.clk, .pufResp, .readAddr(bufAddr), .readData(bufData));

	outputWriter u_write (.clk, .reset, .start(writeStart), .mode,
		.rawResponse(pufResp.rawResponse), .bufAddr, .bufData,
		.outReq(outMemReq), .writeAck(outMemWriteAck), .done(writeDone));

endmodule

/* sim/sircChecker.sv */
/*
 * Checker for the host-session controller
 *  - output memory writes against the expected bytes
 *  - write count, PUF start count and single run clear per session
 *  - mode, challenge and configuration at PUF start
 */
`timescale 1ns/1ps
`include "sircHandler_consts.svh"

module sircChecker (
	input  logic clk,
	input  logic reset,
	input  int sessionNum,
	input  logic [31:0] modeWord,
	input  logic [31:0] challengeWord,
	input  logic [8*`SIRC_PDL_BYTES-1:0] pdlBytes,
	input  logic [8*`SIRC_RESULT_LEN-1:0] expBytes,
	input  sircBusPkg::outMemReq_t outMemReq,
	input  logic outMemWriteAck,
	input  logic runClear,
	input  pufPkg::pufReq_t pufReq,
	output int errorCount,
	output int checkCount,
	output int sessionsDone
);

	int writeCount;          // Accepted writes this session
	int startCount;          // PUF starts this session
	logic prevStart;
	logic prevClear;

	// Mode word 0 calibration, 1 temperature, else test
	function automatic pufPkg::pufMode_t expectedMode(input logic [31:0] word);
		if (word == 32'(`SIRC_MODE_CALIB))
			return pufPkg::ModeCalib;
		if (word == 32'(`SIRC_MODE_TEMP))
			return pufPkg::ModeTemp;
		return pufPkg::ModeTest;
	endfunction

	function automatic int expectedLength(input logic [31:0] word);
		return (word == 32'(`SIRC_MODE_CALIB)) ? 2 : `SIRC_RESULT_LEN;  // Two raw bytes
	endfunction

	task automatic compareValue(input string what, input logic [127:0] expVal,
		input logic [127:0] actVal);
		checkCount++;
		if (expVal !== actVal) begin
			errorCount++;
			$display("FAIL session%0d %s: expected 0x%0h actual 0x%0h",
				sessionNum, what, expVal, actVal);
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			errorCount = 0;
			checkCount = 0;
			sessionsDone = 0;
			writeCount = 0;
			startCount = 0;
			prevStart = 1'b0;
			prevClear = 1'b0;
		end else begin
			// Accepted output write
			if (outMemReq.writeReq && outMemWriteAck) begin
				if (writeCount >= expectedLength(modeWord)) begin
					errorCount++;
					$display("Extra output write in session %0d at address 0x%0h",
						sessionNum, outMemReq.address);
				end else begin
					compareValue($sformatf("address of byte %0d", writeCount),
						128'(writeCount), 128'(outMemReq.address));
					compareValue($sformatf("data byte %0d", writeCount),
						128'(expBytes[8*writeCount +: 8]), 128'(outMemReq.data));
				end
				writeCount++;
			end
			// PUF start is a trigger or a rising testStart
			if (pufReq.trigger || (pufReq.testStart && !prevStart)) begin
				startCount++;
				compareValue("pufReq mode", 128'(expectedMode(modeWord)), 128'(pufReq.mode));
				compareValue("pufReq challenge", 128'(challengeWord), 128'(pufReq.challenge));
				compareValue("pufReq pdlConfig", 128'(pdlBytes), 128'(pufReq.pdlConfig));
			end
			if (runClear) begin
				if (prevClear) begin
					errorCount++;
					$display("runClear high for more than one cycle in session %0d", sessionNum);
				end else begin
					compareValue("write count", 128'(expectedLength(modeWord)), 128'(writeCount));
					compareValue("PUF start count", 128'(1), 128'(startCount));
					writeCount = 0;
					startCount = 0;
					sessionsDone++;
				end
			end
			prevStart = pufReq.testStart;
			prevClear = runClear;
		end
	end

endmodule

/* sim/sircHandlerTb.sv */
/*
 * Testbench for the host-session controller
 *  - clock, reset and session sequencing from the data file
 *  - parameter register, input memory and output memory models
 *  - PUF evaluation model
 *  - watchdog
 */
`timescale 1ns/1ps
`include "sircHandler_consts.svh"

module sircHandlerTb;

	localparam int maxSessions = 32;
	localparam int sessionWords = 11;          // Words per data-file line
	localparam int cyclesPerSession = 2000;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic runValue = 1'b0;
	logic runClear;
	sircBusPkg::regReq_t regReq;
	sircBusPkg::regResp_t regResp = '0;
	sircBusPkg::inMemReq_t inMemReq;
	sircBusPkg::inMemResp_t inMemResp = '0;
	sircBusPkg::outMemReq_t outMemReq;
	logic outMemWriteAck = 1'b0;
	pufPkg::pufReq_t pufReq;
	pufPkg::pufResp_t pufResp = '0;

	// Session data, word 0 is the session count
	logic [31:0] words [1 + maxSessions*sessionWords];
	int numSessions = 0;
	logic loaded = 1'b0;
	int sessionNum = 0;
	logic [31:0] modeWord = '0;
	logic [31:0] challengeWord = '0;
	logic [8*`SIRC_PDL_BYTES-1:0] pdlBytes = '0;      // Input memory contents
	logic [15:0] rawValue = '0;
	logic [8*`SIRC_RESULT_LEN-1:0] expBytes = '0;

	integer seed = 32'hef77_04f7;
	logic [31:0] ackRoll = '0;                        // New random draw every cycle
	logic [1:0] regWait = '0;
	logic [1:0] inWait = '0;
	logic [1:0] outWait = '0;
	logic pufBusy = 1'b0;
	int pufCount = 0;
	int errorCount;
	int checkCount;
	int sessionsDone;
	int endErrors = 0;

	always #20 clk = ~clk;

	sircHandler u_dut (.clk, .reset, .runValue, .runClear, .regReq, .regResp,
		.inMemReq, .inMemResp, .outMemReq, .outMemWriteAck, .pufReq, .pufResp);

	sircChecker u_check (.clk, .reset, .sessionNum, .modeWord, .challengeWord, .pdlBytes,
		.expBytes, .outMemReq, .outMemWriteAck, .runClear, .pufReq,
		.errorCount, .checkCount, .sessionsDone);

	// PUF rule: pdl byte i ^ challenge byte (i mod 4) ^ i
	function automatic logic [7:0] resultByte(input int i);
		return pufReq.pdlConfig[8*i +: 8] ^ pufReq.challenge[8*(i%4) +: 8] ^ 8'(i);
	endfunction

	always @(posedge clk) ackRoll <= $random(seed);

	////////////////////////////////////////
	// Host memory models, ack after 0..3 cycles

	always @(posedge clk) begin
		regResp.cmdAck <= 1'b0;
		regResp.readDataValid <= 1'b0;
		if (regReq.cmdReq && regResp.cmdAck) begin
			regResp.readDataValid <= 1'b1;              // Data one cycle after accept
			regResp.readData <= (regReq.address == '0) ? modeWord : challengeWord;
			regWait <= ackRoll[1:0];
		end else if (regReq.cmdReq) begin
			if (regWait == 2'd0)
				regResp.cmdAck <= 1'b1;
			else
				regWait <= regWait - 2'd1;
		end
	end

	always @(posedge clk) begin
		inMemResp.readAck <= 1'b0;
		inMemResp.readDataValid <= 1'b0;
		if (inMemReq.readReq && inMemResp.readAck) begin
			inMemResp.readDataValid <= 1'b1;
			inMemResp.data <= pdlBytes[8*inMemReq.address[3:0] +: 8];
			inWait <= ackRoll[3:2];
		end else if (inMemReq.readReq) begin
			if (inWait == 2'd0)
				inMemResp.readAck <= 1'b1;
			else
				inWait <= inWait - 2'd1;
		end
	end

	// Output memory only acknowledges, the checker sees the data
	always @(posedge clk) begin
		outMemWriteAck <= 1'b0;
		if (outMemReq.writeReq && outMemWriteAck)
			outWait <= ackRoll[5:4];
		else if (outMemReq.writeReq) begin
			if (outWait == 2'd0)
				outMemWriteAck <= 1'b1;
			else
				outWait <= outWait - 2'd1;
		end
	end

	////////////////////////////////////////
	// PUF model, fills the buffer then reports done

	always @(posedge clk) begin
		pufResp.bufWe <= 1'b0;
		pufResp.testDone <= 1'b0;
		pufResp.rawResponse <= rawValue;                // Calibration reads this
		if (reset) begin
			pufBusy <= 1'b0;
		end else if (pufBusy) begin
			if (pufCount == `SIRC_RESULT_LEN) begin
				pufResp.testDone <= 1'b1;               // Single cycle
				pufBusy <= 1'b0;
			end else begin
				pufResp.bufWe <= 1'b1;
				pufResp.bufAddr <= pufCount[$clog2(`SIRC_RESULT_LEN)-1:0];
				pufResp.bufData <= resultByte(pufCount);
				pufCount <= pufCount + 1;
			end
		end else if (pufReq.testStart && !pufResp.testDone) begin
			pufBusy <= 1'b1;
			pufCount <= 0;
		end
	end

	////////////////////////////////////////
	// Session sequencing

	initial begin
		int base;
		$readmemh("sim/sircHandler_testdata.txt", words);
		numSessions = words[0];
		if (numSessions < 1 || numSessions > maxSessions) begin
			$display("Data file gives no usable session count (%0d)", numSessions);
			endErrors++;
			numSessions = 0;
		end
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		for (int s = 0; s < numSessions; s++) begin
			@(posedge clk);
			base = 1 + s*sessionWords;
			sessionNum <= s + 1;
			modeWord <= words[base];
			challengeWord <= words[base+1];
			pdlBytes <= {words[base+2], words[base+3], words[base+4], words[base+5]};
			rawValue <= words[base+6][15:0];
			expBytes <= {words[base+7], words[base+8], words[base+9], words[base+10]};
			runValue <= 1'b1;                           // Host run flag
			@(posedge clk);
			while (!runClear) @(posedge clk);
			runValue <= 1'b0;                           // Cleared by the DUT pulse
		end
		repeat (4) @(posedge clk);
		if (sessionsDone != numSessions) begin
			$display("Only %0d of %0d sessions cleared the run flag", sessionsDone, numSessions);
			endErrors++;
		end
		$display("Sessions %0d of %0d, checks %0d, errors %0d",
			sessionsDone, numSessions, checkCount, errorCount + endErrors);
		if (errorCount + endErrors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// Watchdog, scaled by the number of sessions
	initial begin
		wait (loaded);
		repeat ((numSessions + 1) * cyclesPerSession) @(posedge clk);
		$display("Watchdog expired, sessions did not finish in %0d cycles",
			(numSessions + 1) * cyclesPerSession);
		$display("Test FAILED");
		$finish;
	end

endmodule

/* sim/sircHandler_testdata.txt */
// First word: number of sessions. Then one session per line, 11 hex words:
// mode challenge pdl[127:96] pdl[95:64] pdl[63:32] pdl[31:0] raw exp[127:96] .. exp[31:0]
// pdl byte i and expected byte at output address i sit at bits 8*i+7..8*i
00000007
// Calibration, raw a55a gives a5 then 5a
00000000 12345678 00000000 00000000 00000000 00000000 0000a55a 00000000 00000000 00000000 00005aa5
// Test, zero challenge and configuration, bytes equal their index
00000002 00000000 00000000 00000000 00000000 00000000 0000beef 0f0e0d0c 0b0a0908 07060504 03020100
// Temperature, all-ones challenge
00000001 ffffffff 00000000 00000000 00000000 00000000 00000000 f0f1f2f3 f4f5f6f7 f8f9fafb fcfdfeff
// Test by an unlisted mode word, distinct configuration bytes
00000005 00000000 00112233 44556677 8899aabb ccddeeff 00000000 0f1f2f3f 4f5f6f7f 8f9fafbf cfdfefff
// Test, challenge bytes differ per lane
00000002 01020304 00000000 00000000 00000000 00000000 00000000 0e0c0e08 0a080a0c 06040600 02000204
// Calibration between buffer sessions
00000000 deadbeef 00112233 44556677 8899aabb ccddeeff 00001234 00000000 00000000 00000000 00003412
// Temperature, all-ones configuration
00000001 00ff00ff ffffffff ffffffff ffffffff ffffffff 00000000 f00ef20c f40af608 f806fa04 fc02fe00

/* project.f */
+incdir+include
design/sircBusPkg.sv
design/pufPkg.sv
design/paramFetch.sv
design/challengeLoader.sv
design/resultBuffer.sv
design/outputWriter.sv
design/sessionControl.sv
design/sircHandler.sv
sim/sircChecker.sv
sim/sircHandlerTb.sv

/* Makefile */
# Verilator flow for the host-session controller testbench
TOP := sircHandlerTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

# Pass only when the run prints the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -x "Test OK" > /dev/null

clean:
	rm -rf obj_dir
